//--- hdl/reg_map_pkg.sv
////////////////////////////////////////////////////////////
// Register map of the host bus. Each block owns a 256-byte
// page and only its first four words are decoded
////////////////////////////////////////////////////////////
`default_nettype none

package reg_map_pkg;

    // Decoded block select
    typedef enum logic [1:0] {
        BLK_SP   = 2'd0,
        BLK_CLK  = 2'd1,
        BLK_OSC  = 2'd2,
        BLK_NONE = 2'd3
    } blk_e;

    // Block base addresses, address bits 11:8 pick the page
    localparam logic [11:0] SP_BASE  = 12'h000;
    localparam logic [11:0] CLK_BASE = 12'h100;
    localparam logic [11:0] OSC_BASE = 12'h200;

    // Scratch-pad block
    localparam logic [11:0] SP_VERSION = 12'h000;
    localparam logic [11:0] SP_ID      = 12'h004;
    localparam logic [11:0] SP_DATE    = 12'h008;
    localparam logic [11:0] SP_SCRATCH = 12'h00C;

    // Pulse generator block
    localparam logic [11:0] CLK_DIV_TICK = 12'h000;
    localparam logic [11:0] CLK_DIV_LED  = 12'h004;

    // Oscillator counter block
    localparam logic [11:0] OSC_CTRL   = 12'h000;
    localparam logic [11:0] OSC_STATUS = 12'h004;
    localparam logic [11:0] OSC_PERIOD = 12'h008;

    localparam int DIV_W    = 16;
    localparam int PERIOD_W = 24;

    localparam logic [31:0] BAD_ADDR_DATA = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

//--- hdl/opb_pkg.sv
////////////////////////////////////////////////////////////
// Host bus types. Single-cycle request, no back-pressure
////////////////////////////////////////////////////////////
`default_nettype none

package opb_pkg;

    import reg_map_pkg::blk_e;

    localparam int OPB_ADDR_W = 12;
    localparam int OPB_DATA_W = 32;

    typedef enum logic [1:0] {
        OPB_NOP   = 2'd0,
        OPB_READ  = 2'd1,
        OPB_WRITE = 2'd2
    } opb_op_e;

    // Request as driven by the host
    typedef struct packed {
        opb_op_e                 op;
        logic [OPB_ADDR_W-1:0]   addr;
        logic [OPB_DATA_W-1:0]   wdata;
    } opb_req_t;

    // Registered request after address decode
    typedef struct packed {
        opb_op_e                 op;
        blk_e                    blk;
        logic [1:0]              reg_idx;
        logic [OPB_DATA_W-1:0]   wdata;
    } opb_dec_t;

    typedef struct packed {
        logic                    valid;
        logic [OPB_DATA_W-1:0]   data;
    } opb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/opb_decode.sv
////////////////////////////////////////////////////////////
// Address bits 7:4 must be zero, otherwise the access maps
// to no block. Bits 1:0 are ignored
////////////////////////////////////////////////////////////
`default_nettype none

module opb_decode (
    input  logic               clk_100m,
    input  logic               rst,
    input  opb_pkg::opb_req_t  req,
    output opb_pkg::opb_dec_t  dec
);

    import opb_pkg::*;
    import reg_map_pkg::*;

    blk_e                   blk_d;
    opb_op_e                op_q;
    blk_e                   blk_q;
    logic [1:0]             reg_idx_q;
    logic [OPB_DATA_W-1:0]  wdata_q;

    // Page lookup
    always_comb begin
        blk_d = BLK_NONE;
        if (req.addr[7:4] == 4'h0) begin
            if (req.addr[11:8] == SP_BASE[11:8]) begin
                blk_d = BLK_SP;
            end else if (req.addr[11:8] == CLK_BASE[11:8]) begin
                blk_d = BLK_CLK;
            end else if (req.addr[11:8] == OSC_BASE[11:8]) begin
                blk_d = BLK_OSC;
            end
        end
    end

    // Op is the only control field
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            op_q <= OPB_NOP;
        end else begin
            op_q <= req.op;
        end
    end

    always_ff @(posedge clk_100m) begin
        blk_q     <= blk_d;
        reg_idx_q <= req.addr[3:2];
        wdata_q   <= req.wdata;
    end

    assign dec = '{op: op_q, blk: blk_q, reg_idx: reg_idx_q, wdata: wdata_q};

endmodule

`default_nettype wire

//--- hdl/scratch_pad.sv
////////////////////////////////////////////////////////////
// Identification words are fixed at build time
////////////////////////////////////////////////////////////
`default_nettype none

module scratch_pad #(
    parameter logic [31:0] FW_VERSION = 32'h0000_0001,
    parameter logic [31:0] FPGA_ID    = 32'h0000_0050,
    parameter logic [31:0] BUILD_DATE = 32'h0000_0000
) (
    input  logic                            clk_100m,
    input  logic                            rst,
    input  opb_pkg::opb_dec_t               dec,
    output logic [opb_pkg::OPB_DATA_W-1:0]  rd_data
);

    import opb_pkg::*;
    import reg_map_pkg::*;

    logic [OPB_DATA_W-1:0]  scratch_q;
    logic                   wr_scratch;

    assign wr_scratch = (dec.op == OPB_WRITE) && (dec.blk == BLK_SP)
                        && (dec.reg_idx == SP_SCRATCH[3:2]);

    // Only the scratch word is writable
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            scratch_q <= '0;
        end else if (wr_scratch) begin
            scratch_q <= dec.wdata;
        end
    end

    always_comb begin
        case (dec.reg_idx)
            SP_VERSION[3:2]: rd_data = FW_VERSION;
            SP_ID[3:2]:      rd_data = FPGA_ID;
            SP_DATE[3:2]:    rd_data = BUILD_DATE;
            SP_SCRATCH[3:2]: rd_data = scratch_q;
            default:         rd_data = BAD_ADDR_DATA;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/pulse_gen.sv
////////////////////////////////////////////////////////////
// A divider of zero gives a period of 65536. Writing either
// divider restarts both counters, the LED level is kept
////////////////////////////////////////////////////////////
`default_nettype none

module pulse_gen #(
    parameter logic [reg_map_pkg::DIV_W-1:0] DIV_TICK_RESET = 16'd50000,
    parameter logic [reg_map_pkg::DIV_W-1:0] DIV_LED_RESET  = 16'd1000
) (
    input  logic                            clk_100m,
    input  logic                            rst,
    input  opb_pkg::opb_dec_t               dec,
    output logic [opb_pkg::OPB_DATA_W-1:0]  rd_data,
    output logic                            tick,
    output logic                            led
);

    import opb_pkg::*;
    import reg_map_pkg::*;

    logic [DIV_W-1:0]  div_tick_q;
    logic [DIV_W-1:0]  div_led_q;
    logic [DIV_W-1:0]  cyc_cnt;
    logic [DIV_W-1:0]  tick_cnt;
    logic              wr_en;
    logic              wr_tick;
    logic              wr_led;
    logic              cyc_end;
    logic              led_end;

    assign wr_en   = (dec.op == OPB_WRITE) && (dec.blk == BLK_CLK);
    assign wr_tick = wr_en && (dec.reg_idx == CLK_DIV_TICK[3:2]);
    assign wr_led  = wr_en && (dec.reg_idx == CLK_DIV_LED[3:2]);

    // Terminal counts
    assign cyc_end = (cyc_cnt == div_tick_q - DIV_W'(1));
    assign led_end = (tick_cnt == div_led_q - DIV_W'(1));

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            div_tick_q <= DIV_TICK_RESET;
            div_led_q  <= DIV_LED_RESET;
        end else begin
            if (wr_tick) begin
                div_tick_q <= dec.wdata[DIV_W-1:0];
            end
            if (wr_led) begin
                div_led_q <= dec.wdata[DIV_W-1:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Tick and LED counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            cyc_cnt  <= '0;
            tick_cnt <= '0;
            tick     <= 1'b0;
            led      <= 1'b0;
        end else if (wr_tick || wr_led) begin
            cyc_cnt  <= '0;
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= cyc_end;
            if (cyc_end) begin
                cyc_cnt <= '0;
                // LED flips together with the last tick of a group
                if (led_end) begin
                    tick_cnt <= '0;
                    led      <= ~led;
                end else begin
                    tick_cnt <= tick_cnt + DIV_W'(1);
                end
            end else begin
                cyc_cnt <= cyc_cnt + DIV_W'(1);
            end
        end
    end

    always_comb begin
        case (dec.reg_idx)
            CLK_DIV_TICK[3:2]: rd_data = OPB_DATA_W'(div_tick_q);
            CLK_DIV_LED[3:2]:  rd_data = OPB_DATA_W'(div_led_q);
            default:           rd_data = BAD_ADDR_DATA;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/osc_counter.sv
////////////////////////////////////////////////////////////
// Ref clock must be slower than half of clk_100m. Counts
// saturate at the top of PERIOD_W, a new start restarts
////////////////////////////////////////////////////////////
`default_nettype none

module osc_counter #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                            clk_100m,
    input  logic                            rst,
    input  opb_pkg::opb_dec_t               dec,
    input  logic                            ref_clk,
    output logic [opb_pkg::OPB_DATA_W-1:0]  rd_data
);

    import opb_pkg::*;
    import reg_map_pkg::*;

    typedef enum logic [1:0] {
        OSC_IDLE,
        OSC_WAIT_EDGE,
        OSC_COUNT,
        OSC_DONE
    } osc_state_e;

    osc_state_e           state;
    logic [SYNC_STAGES:0] sync_q;
    logic                 ref_rise;
    logic                 start;
    logic [PERIOD_W-1:0]  cnt;
    logic [PERIOD_W-1:0]  period_q;

    assign start = (dec.op == OPB_WRITE) && (dec.blk == BLK_OSC)
                   && (dec.reg_idx == OSC_CTRL[3:2]) && dec.wdata[0];

    // Synchronizer plus one stage for edge detect
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-1:0], ref_clk};
        end
    end

    assign ref_rise = sync_q[SYNC_STAGES-1] & ~sync_q[SYNC_STAGES];

    ////////////////////////////////////////////////////////////
    // Measurement FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state    <= OSC_IDLE;
            period_q <= '0;
        end else if (start) begin
            state <= OSC_WAIT_EDGE;
        end else begin
            case (state)
                OSC_WAIT_EDGE: if (ref_rise) state <= OSC_COUNT;
                OSC_COUNT: begin
                    if (ref_rise) begin
                        period_q <= cnt;
                        state    <= OSC_DONE;
                    end
                end
                default: state <= state;
            endcase
        end
    end

    // Cycle count since the first edge
    always_ff @(posedge clk_100m) begin
        if (state == OSC_WAIT_EDGE) begin
            cnt <= PERIOD_W'(1);
        end else if (state == OSC_COUNT && cnt != '1) begin
            cnt <= cnt + PERIOD_W'(1);
        end
    end

    always_comb begin
        case (dec.reg_idx)
            OSC_CTRL[3:2]:   rd_data = OPB_DATA_W'(state == OSC_WAIT_EDGE || state == OSC_COUNT);
            OSC_STATUS[3:2]: rd_data = OPB_DATA_W'(state == OSC_DONE);
            OSC_PERIOD[3:2]: rd_data = OPB_DATA_W'(period_q);
            default:         rd_data = BAD_ADDR_DATA;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/opb_read_mux.sv
////////////////////////////////////////////////////////////
// Response data only updates on reads
////////////////////////////////////////////////////////////
`default_nettype none

module opb_read_mux (
    input  logic                            clk_100m,
    input  logic                            rst,
    input  opb_pkg::opb_dec_t               dec,
    input  logic [opb_pkg::OPB_DATA_W-1:0]  sp_data,
    input  logic [opb_pkg::OPB_DATA_W-1:0]  clk_data,
    input  logic [opb_pkg::OPB_DATA_W-1:0]  osc_data,
    output opb_pkg::opb_rsp_t               rsp
);

    import opb_pkg::*;
    import reg_map_pkg::*;

    logic [OPB_DATA_W-1:0]  sel_data;
    logic [OPB_DATA_W-1:0]  data_q;
    logic                   valid_q;

    always_comb begin
        case (dec.blk)
            BLK_SP:  sel_data = sp_data;
            BLK_CLK: sel_data = clk_data;
            BLK_OSC: sel_data = osc_data;
            default: sel_data = BAD_ADDR_DATA;
        endcase
    end

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= (dec.op == OPB_READ);
        end
    end

    always_ff @(posedge clk_100m) begin
        if (dec.op == OPB_READ) begin
            data_q <= sel_data;
        end
    end

    assign rsp = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

//--- hdl/top_hw.sv
////////////////////////////////////////////////////////////
// Single clock domain on clk_100m. Read response arrives
// two cycles after the request
////////////////////////////////////////////////////////////
`default_nettype none

module top_hw #(
    parameter logic [31:0]                   FW_VERSION     = 32'h0000_0001,
    parameter logic [31:0]                   FPGA_ID        = 32'h0000_0050,
    // Packed BCD build date, filled in by the build flow
    parameter logic [31:0]                   BUILD_DATE     = 32'h0000_0000,
    parameter logic [reg_map_pkg::DIV_W-1:0] DIV_TICK_RESET = 16'd50000,
    parameter logic [reg_map_pkg::DIV_W-1:0] DIV_LED_RESET  = 16'd1000,
    parameter int                            SYNC_STAGES    = 2
) (
    input  logic               clk_100m,
    input  logic               rst,
    input  opb_pkg::opb_req_t  opb_req,
    output opb_pkg::opb_rsp_t  opb_rsp,
    input  logic               ref_clk_in,
    output logic               clkout_2khz,
    output logic               stat_led
);

    import opb_pkg::*;

    opb_dec_t               dec;
    logic [OPB_DATA_W-1:0]  sp_data;
    logic [OPB_DATA_W-1:0]  clk_data;
    logic [OPB_DATA_W-1:0]  osc_data;

    // Decode
    opb_decode u_opb_decode (
        .clk_100m (clk_100m),
        .rst      (rst),
        .req      (opb_req),
        .dec      (dec)
    );

    ////////////////////////////////////////////////////////////
    // Register blocks
    ////////////////////////////////////////////////////////////
    scratch_pad #(
        .FW_VERSION (FW_VERSION),
        .FPGA_ID    (FPGA_ID),
        .BUILD_DATE (BUILD_DATE)
    ) u_scratch_pad (
        .clk_100m (clk_100m),
        .rst      (rst),
        .dec      (dec),
        .rd_data  (sp_data)
    );

    pulse_gen #(
        .DIV_TICK_RESET (DIV_TICK_RESET),
        .DIV_LED_RESET  (DIV_LED_RESET)
    ) u_pulse_gen (
        .clk_100m (clk_100m),
        .rst      (rst),
        .dec      (dec),
        .rd_data  (clk_data),
        .tick     (clkout_2khz),
        .led      (stat_led)
    );

    osc_counter #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_osc_counter (
        .clk_100m (clk_100m),
        .rst      (rst),
        .dec      (dec),
        .ref_clk  (ref_clk_in),
        .rd_data  (osc_data)
    );

    // Read-back
    opb_read_mux u_opb_read_mux (
        .clk_100m (clk_100m),
        .rst      (rst),
        .dec      (dec),
        .sp_data  (sp_data),
        .clk_data (clk_data),
        .osc_data (osc_data),
        .rsp      (opb_rsp)
    );

endmodule

`default_nettype wire

//--- tb/tb_checks.svh
////////////////////////////////////////////////////////////
// Included inside tb_top_hw, relies on its rng and report_fail
////////////////////////////////////////////////////////////
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// 32-bit xorshift, state kept in rng
function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

task automatic check_rsp(input opb_rsp_t got, input opb_rsp_t exp, input string what);
    if (got !== exp) begin
        report_fail($sformatf("FAILED at time %0t: %s, got valid %0b data %08h, exp %0b %08h",
                              $time, what, got.valid, got.data, exp.valid, exp.data));
    end
endtask

task automatic check_period(input logic [PERIOD_W-1:0] got, input logic [PERIOD_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
        report_fail($sformatf("FAILED at time %0t: %s, got %0d expected %0d",
                              $time, what, got, exp));
    end
endtask

task automatic check_div(input logic [DIV_W-1:0] got, input logic [DIV_W-1:0] exp,
                         input string what);
    if (got !== exp) begin
        report_fail($sformatf("FAILED at time %0t: %s, got %0d expected %0d",
                              $time, what, got, exp));
    end
endtask

task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        report_fail($sformatf("FAILED at time %0t: %s, got %b expected %b",
                              $time, what, got, exp));
    end
endtask

`endif

//--- tb/tb_top_hw.sv
////////////////////////////////////////////////////////////
// Runs with small divider values. The reference period must
// be at least 4 system clock cycles
////////////////////////////////////////////////////////////
`default_nettype none

module tb_top_hw;

    import opb_pkg::*;
    import reg_map_pkg::*;

    localparam logic [31:0]      FW_VERSION     = 32'h0001_0203;
    localparam logic [31:0]      FPGA_ID        = 32'h0000_0050;
    localparam logic [31:0]      BUILD_DATE     = 32'hB17D_0A7E;
    localparam logic [DIV_W-1:0] DIV_TICK_RESET = 16'd20;
    localparam logic [DIV_W-1:0] DIV_LED_RESET  = 16'd4;
    localparam logic [DIV_W-1:0] TICK_NEW       = 16'd7;
    localparam logic [DIV_W-1:0] LED_NEW        = 16'd3;
    localparam int RST_CYCLES   = 4;
    localparam int TBL_LEN      = 26;
    localparam int N_A          = 12;
    localparam int N_B          = 37;
    localparam int OSC_BUDGET   = 4 * (N_A + N_B) + 60;
    localparam int PULSE_BUDGET = 2 * (int'(LED_NEW) + 1) * int'(TICK_NEW) + 20;
    localparam int WATCHDOG_CYCLES = 4 * (RST_CYCLES + TBL_LEN + OSC_BUDGET + PULSE_BUDGET);

    // Read waiting for its response
    typedef struct {
        int unsigned due;
        bit          chk;
        opb_rsp_t    exp;
        string       what;
    } pend_t;

    logic         clk = 1'b0;
    logic         rst;
    opb_req_t     opb_req;
    opb_rsp_t     opb_rsp;
    logic         ref_clk_in = 1'b0;
    logic         clkout_2khz;
    logic         stat_led;

    opb_req_t     tbl_req [TBL_LEN];
    opb_rsp_t     tbl_exp [TBL_LEN];
    string        tbl_what [TBL_LEN];
    pend_t        exp_q [$];
    opb_rsp_t     poll_rsp;
    int unsigned  cyc = 0;
    int           ref_period = 0;
    int           ref_phase = 0;
    logic [31:0]  rng = 32'd56;

    top_hw #(
        .FW_VERSION     (FW_VERSION),
        .FPGA_ID        (FPGA_ID),
        .BUILD_DATE     (BUILD_DATE),
        .DIV_TICK_RESET (DIV_TICK_RESET),
        .DIV_LED_RESET  (DIV_LED_RESET)
    ) dut_i (
        .clk_100m    (clk),
        .rst         (rst),
        .opb_req     (opb_req),
        .opb_rsp     (opb_rsp),
        .ref_clk_in  (ref_clk_in),
        .clkout_2khz (clkout_2khz),
        .stat_led    (stat_led)
    );

    always #5 clk = ~clk;

    // Reference clock with one rising edge every ref_period cycles
    always @(posedge clk) begin
        if (ref_period < 4) begin
            ref_clk_in <= 1'b0;
            ref_phase  <= 0;
        end else begin
            ref_clk_in <= (ref_phase < ref_period / 2);
            ref_phase  <= (ref_phase >= ref_period - 1) ? 0 : ref_phase + 1;
        end
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    `include "tb_checks.svh"

    ////////////////////////////////////////////////////////////
    // Response checker sampled on the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!rst) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                if (exp_q[0].chk) begin
                    check_rsp(opb_rsp, exp_q[0].exp, exp_q[0].what);
                end else begin
                    check_level(opb_rsp.valid, 1'b1, exp_q[0].what);
                    poll_rsp = opb_rsp;
                end
                void'(exp_q.pop_front());
            end else begin
                check_level(opb_rsp.valid, 1'b0, "response valid with no read pending");
            end
        end
        cyc <= cyc + 1;
    end

    function automatic opb_req_t make_req(input opb_op_e op, input logic [11:0] addr,
                                          input logic [31:0] wdata);
        opb_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    task automatic post_req(input opb_req_t r, input bit chk, input opb_rsp_t exp,
                            input string what);
        pend_t p;
        @(posedge clk);
        opb_req <= r;
        // Read data is due two cycles after the request
        if (r.op == OPB_READ) begin
            p.due  = cyc + 2;
            p.chk  = chk;
            p.exp  = exp;
            p.what = what;
            exp_q.push_back(p);
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        opb_req <= make_req(OPB_NOP, '0, '0);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic bus_read(input logic [11:0] addr, input string what, output opb_rsp_t rsp);
        post_req(make_req(OPB_READ, addr, '0), 1'b0, '0, what);
        go_idle();
        drain();
        rsp = poll_rsp;
    endtask

    task automatic set_entry(input int i, input opb_op_e op, input logic [11:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp_data,
                             input string what);
        tbl_req[i]  = make_req(op, addr, wdata);
        tbl_exp[i]  = '{valid: 1'b1, data: exp_data};
        tbl_what[i] = what;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////
    task automatic build_table();
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] s3;
        s1 = xorshift32();
        s2 = xorshift32();
        s3 = xorshift32();
        set_entry(0, OPB_READ, SP_BASE | SP_VERSION, '0, FW_VERSION, "version");
        set_entry(1, OPB_READ, SP_BASE | SP_ID, '0, FPGA_ID, "fpga id");
        set_entry(2, OPB_READ, SP_BASE | SP_DATE, '0, BUILD_DATE, "build date");
        set_entry(3, OPB_WRITE, SP_BASE | SP_VERSION, xorshift32(), '0, "");
        set_entry(4, OPB_WRITE, SP_BASE | SP_ID, xorshift32(), '0, "");
        set_entry(5, OPB_WRITE, SP_BASE | SP_DATE, xorshift32(), '0, "");
        set_entry(6, OPB_READ, SP_BASE | SP_VERSION, '0, FW_VERSION, "version after write");
        set_entry(7, OPB_READ, SP_BASE | SP_ID, '0, FPGA_ID, "fpga id after write");
        set_entry(8, OPB_READ, SP_BASE | SP_DATE, '0, BUILD_DATE, "build date after write");
        set_entry(9, OPB_WRITE, SP_BASE | SP_SCRATCH, s1, '0, "");
        set_entry(10, OPB_READ, SP_BASE | SP_SCRATCH, '0, s1, "scratch first");
        set_entry(11, OPB_WRITE, SP_BASE | SP_SCRATCH, s2, '0, "");
        set_entry(12, OPB_READ, SP_BASE | SP_SCRATCH, '0, s2, "scratch second");
        set_entry(13, OPB_WRITE, SP_BASE | SP_SCRATCH, s3, '0, "");
        set_entry(14, OPB_READ, SP_BASE | SP_SCRATCH, '0, s3, "scratch third");
        set_entry(15, OPB_READ, 12'h300, '0, BAD_ADDR_DATA, "unmapped base 0x300");
        set_entry(16, OPB_READ, 12'hF04, '0, BAD_ADDR_DATA, "unmapped base 0xF00");
        set_entry(17, OPB_READ, CLK_BASE | 12'h008, '0, BAD_ADDR_DATA, "clock unused index");
        set_entry(18, OPB_READ, OSC_BASE | 12'h00C, '0, BAD_ADDR_DATA, "osc unused index");
        set_entry(19, OPB_WRITE, 12'h30C, xorshift32(), '0, "");
        set_entry(20, OPB_READ, SP_BASE | SP_SCRATCH, '0, s3, "scratch after unmapped write");
        set_entry(21, OPB_READ, CLK_BASE | CLK_DIV_TICK, '0, 32'(DIV_TICK_RESET), "tick div reset");
        set_entry(22, OPB_WRITE, CLK_BASE | CLK_DIV_TICK, 32'(TICK_NEW), '0, "");
        set_entry(23, OPB_WRITE, CLK_BASE | CLK_DIV_LED, 32'(LED_NEW), '0, "");
        set_entry(24, OPB_READ, CLK_BASE | CLK_DIV_TICK, '0, 32'(TICK_NEW), "tick div readback");
        set_entry(25, OPB_READ, CLK_BASE | CLK_DIV_LED, '0, 32'(LED_NEW), "led div readback");
    endtask

    // Pulse spacing and LED toggle rate over two toggles
    task automatic watch_pulses(input logic [DIV_W-1:0] tick_div,
                                input logic [DIV_W-1:0] led_div);
        int   gap;
        int   since_toggle;
        int   toggles;
        bit   seen;
        logic led_prev;
        gap          = 0;
        since_toggle = 0;
        toggles      = 0;
        seen         = 1'b0;
        led_prev     = stat_led;
        while (toggles < 2) begin
            @(negedge clk);
            gap++;
            if (clkout_2khz) begin
                if (seen) begin
                    check_div(DIV_W'(gap), tick_div, "gap between pulses");
                end
                seen = 1'b1;
                gap  = 0;
                since_toggle++;
            end
            if (stat_led !== led_prev) begin
                if (toggles > 0) begin
                    check_div(DIV_W'(since_toggle), led_div, "pulses per led toggle");
                end
                toggles++;
                since_toggle = 0;
                led_prev     = stat_led;
            end
        end
    endtask

    task automatic measure(input int n);
        opb_rsp_t rsp;
        opb_rsp_t idle_rsp;
        idle_rsp = '{valid: 1'b1, data: '0};
        @(posedge clk);
        ref_period <= n;
        repeat (2 * n) @(posedge clk);
        post_req(make_req(OPB_WRITE, OSC_BASE | OSC_CTRL, 32'd1), 1'b0, '0, "");
        post_req(make_req(OPB_READ, OSC_BASE | OSC_STATUS, '0), 1'b1, idle_rsp,
                 "done cleared by start");
        go_idle();
        drain();
        do begin
            bus_read(OSC_BASE | OSC_STATUS, "status poll", rsp);
        end while (rsp.data[0] !== 1'b1);
        bus_read(OSC_BASE | OSC_PERIOD, "period read", rsp);
        check_period(rsp.data[PERIOD_W-1:0], PERIOD_W'(n), "measured reference period");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rst     <= 1'b1;
        opb_req <= make_req(OPB_NOP, '0, '0);
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_level(opb_rsp.valid, 1'b0, "valid after reset");
        check_level(clkout_2khz, 1'b0, "pulse after reset");
        check_level(stat_led, 1'b0, "led after reset");
        for (int i = 0; i < TBL_LEN; i++) begin
            post_req(tbl_req[i], 1'b1, tbl_exp[i], tbl_what[i]);
        end
        go_idle();
        drain();
        watch_pulses(TICK_NEW, LED_NEW);
        measure(N_A);
        measure(N_B);
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_fail($sformatf("Timeout: the run did not finish within %0d clock cycles",
                              WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire

//--- top_hw.f
+incdir+tb
hdl/reg_map_pkg.sv
hdl/opb_pkg.sv
hdl/opb_decode.sv
hdl/scratch_pad.sv
hdl/pulse_gen.sv
hdl/osc_counter.sv
hdl/opb_read_mux.sv
hdl/top_hw.sv
tb/tb_top_hw.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --top-module tb_top_hw -f top_hw.f -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
